// File: logic/bit_rate_timer.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module bit_rate_timer #(
   parameter int PERIOD = `DDS_BIT_PERIOD
)
(
   input  logic CLK_25MHZ,
   input  logic reset_from_key,
   output logic bit_tick
);

   localparam int               CNT_W  = (PERIOD > 1) ? $clog2(PERIOD) : 1;
   localparam logic [CNT_W-1:0] RELOAD = CNT_W'(PERIOD - 1);

   logic [CNT_W-1:0] count;   // cycles left before the next tick

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         count    <= RELOAD;
         bit_tick <= 1'b0;
      end
      else if (count == '0)
      begin
         count    <= RELOAD;   // terminal count
         bit_tick <= 1'b1;
      end
      else
      begin
         count    <= count - 1'b1;
         bit_tick <= 1'b0;
      end
   end

endmodule

// File: logic/dds_core.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module dds_core
   import dds_pkg::*;
(
   input  logic                     CLK_25MHZ,
   input  logic                     reset_from_key,
   input  logic [`DDS_PHASE_W-1:0]  phase_inc,
   input  wave_sel_t                wave_sel,
   output logic [`DDS_SAMPLE_W-1:0] carrier
);

   // full scale of a signed sample
   localparam logic [`DDS_SAMPLE_W-1:0] SQ_HIGH = {1'b0, {(`DDS_SAMPLE_W-1){1'b1}}};
   localparam logic [`DDS_SAMPLE_W-1:0] SQ_LOW  = {1'b1, {(`DDS_SAMPLE_W-1){1'b0}}};

   logic [`DDS_PHASE_W-1:0]  phase;
   logic [`DDS_SAMPLE_W-1:0] saw_wave;
   logic [`DDS_SAMPLE_W-1:0] squ_wave;

   ////////////////////
   // phase accumulator
   ////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase <= '0;
      else
         phase <= phase + phase_inc;   // wraps mod 2^32
   end

   ////////////////////
   // waveforms
   ////////////////////

   // top phase bits read as signed give the ramp
   assign saw_wave = phase[`DDS_PHASE_W-1 -: `DDS_SAMPLE_W];

   // first half of the cycle positive
   assign squ_wave = phase[`DDS_PHASE_W-1] ? SQ_LOW : SQ_HIGH;

   assign carrier = (wave_sel == WAVE_SQUARE) ? squ_wave : saw_wave;

endmodule

// File: logic/dds_lab_top.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module dds_lab_top
   import dds_pkg::*;
(
   input  logic                     CLK_25MHZ,
   input  logic                     reset_from_key,
   input  logic [`DDS_PHASE_W-1:0]  phase_inc,
   input  wave_sel_t                wave_sel,
   input  mod_sel_t                 mod_sel,
   input  logic                     event_valid,
   input  logic [`DDS_CODE_W-1:0]   event_code,
   output logic [`DDS_NUM_KEYS-1:0] held_keys,
   output logic                     data_bit,
   output logic [`DDS_SAMPLE_W-1:0] carrier_out,
   output logic [`DDS_SAMPLE_W-1:0] mod_out
);

   logic                     bit_tick;   // one cycle per data bit
   logic [`DDS_SAMPLE_W-1:0] carrier;    // unregistered, straight off the phase

   ////////////////////
   // keyboard
   ////////////////////

   key_tracker u_keys (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .event_valid    (event_valid),
      .event_code     (event_code),
      .held_keys      (held_keys)
   );

   ////////////////////
   // data source
   ////////////////////

   bit_rate_timer #(
      .PERIOD (`DDS_BIT_PERIOD)
   ) u_timer (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .bit_tick       (bit_tick)
   );

   lfsr_gen u_lfsr (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .bit_tick       (bit_tick),
      .data_bit       (data_bit)
   );

   ////////////////////
   // carrier and modulation
   ////////////////////

   dds_core u_dds (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .wave_sel       (wave_sel),
      .carrier        (carrier)
   );

   modulator u_mod (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .carrier        (carrier),
      .data_bit       (data_bit),
      .mod_sel        (mod_sel),
      .carrier_out    (carrier_out),
      .mod_out        (mod_out)
   );

endmodule

// File: logic/dds_pkg.sv
package dds_pkg;

   // carrier shape
   typedef enum logic
   {
      WAVE_SAW    = 1'b0,
      WAVE_SQUARE = 1'b1
   } wave_sel_t;

   // output modulation, same order as the old output mux
   typedef enum logic [1:0]
   {
      MOD_ASK     = 2'd0,
      MOD_BPSK    = 2'd1,
      MOD_BIT     = 2'd2,
      MOD_CARRIER = 2'd3
   } mod_sel_t;

   // bit position of each key in held_keys
   typedef enum logic [4:0]
   {
      KEY_DOWN  = 5'd0,
      KEY_UP    = 5'd1,
      KEY_RIGHT = 5'd2,
      KEY_LEFT  = 5'd3,
      KEY_SPACE = 5'd4,
      KEY_M     = 5'd5,
      KEY_N     = 5'd6,
      KEY_F2    = 5'd7,
      KEY_F1    = 5'd8,
      KEY_8     = 5'd9,
      KEY_7     = 5'd10,
      KEY_6     = 5'd11,
      KEY_5     = 5'd12,
      KEY_4     = 5'd13,
      KEY_3     = 5'd14,
      KEY_2     = 5'd15,
      KEY_1     = 5'd16
   } key_idx_t;

endpackage

// File: logic/dds_settings.svh
`ifndef DDS_SETTINGS_SVH
`define DDS_SETTINGS_SVH

////////////////////
// datapath widths
////////////////////

`define DDS_PHASE_W      32   // phase accumulator
`define DDS_SAMPLE_W     12   // signed two's complement samples
`define DDS_LFSR_W       5
`define DDS_CODE_W       8    // keyboard event code

// cycles between data-bit ticks, short for simulation
`define DDS_BIT_PERIOD   25

`define DDS_NUM_KEYS     17

////////////////////
// key event codes
////////////////////

// make codes, set 2 single byte
`define SC_MAKE_1        8'h16
`define SC_MAKE_2        8'h1E
`define SC_MAKE_3        8'h26
`define SC_MAKE_4        8'h25
`define SC_MAKE_5        8'h2E
`define SC_MAKE_6        8'h36
`define SC_MAKE_7        8'h3D
`define SC_MAKE_8        8'h3E
`define SC_MAKE_F1       8'h05
`define SC_MAKE_F2       8'h06
`define SC_MAKE_N        8'h31
`define SC_MAKE_M        8'h3A
`define SC_MAKE_SPACE    8'h29
`define SC_MAKE_LEFT     8'h6B
`define SC_MAKE_RIGHT    8'h74
`define SC_MAKE_UP       8'h75
`define SC_MAKE_DOWN     8'h72

// break codes are the make code with bit 7 set
`define SC_BREAK_1       8'h96
`define SC_BREAK_2       8'h9E
`define SC_BREAK_3       8'hA6
`define SC_BREAK_4       8'hA5
`define SC_BREAK_5       8'hAE
`define SC_BREAK_6       8'hB6
`define SC_BREAK_7       8'hBD
`define SC_BREAK_8       8'hBE
`define SC_BREAK_F1      8'h85
`define SC_BREAK_F2      8'h86
`define SC_BREAK_N       8'hB1
`define SC_BREAK_M       8'hBA
`define SC_BREAK_SPACE   8'hA9
`define SC_BREAK_LEFT    8'hEB
`define SC_BREAK_RIGHT   8'hF4
`define SC_BREAK_UP      8'hF5
`define SC_BREAK_DOWN    8'hF2

`endif

// File: logic/key_tracker.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module key_tracker
   import dds_pkg::*;
(
   input  logic                     CLK_25MHZ,
   input  logic                     reset_from_key,
   input  logic                     event_valid,
   input  logic [`DDS_CODE_W-1:0]   event_code,
   output logic [`DDS_NUM_KEYS-1:0] held_keys
);

   logic [`DDS_NUM_KEYS-1:0] make_hit;    // one-hot, key went down
   logic [`DDS_NUM_KEYS-1:0] break_hit;   // one-hot, key came up

   // decode the event code against all 34 codes
   always_comb
   begin
      make_hit  = '0;
      break_hit = '0;
      case (event_code)
         `SC_MAKE_1      : make_hit[KEY_1]      = 1'b1;
         `SC_MAKE_2      : make_hit[KEY_2]      = 1'b1;
         `SC_MAKE_3      : make_hit[KEY_3]      = 1'b1;
         `SC_MAKE_4      : make_hit[KEY_4]      = 1'b1;
         `SC_MAKE_5      : make_hit[KEY_5]      = 1'b1;
         `SC_MAKE_6      : make_hit[KEY_6]      = 1'b1;
         `SC_MAKE_7      : make_hit[KEY_7]      = 1'b1;
         `SC_MAKE_8      : make_hit[KEY_8]      = 1'b1;
         `SC_MAKE_F1     : make_hit[KEY_F1]     = 1'b1;
         `SC_MAKE_F2     : make_hit[KEY_F2]     = 1'b1;
         `SC_MAKE_N      : make_hit[KEY_N]      = 1'b1;
         `SC_MAKE_M      : make_hit[KEY_M]      = 1'b1;
         `SC_MAKE_SPACE  : make_hit[KEY_SPACE]  = 1'b1;
         `SC_MAKE_LEFT   : make_hit[KEY_LEFT]   = 1'b1;
         `SC_MAKE_RIGHT  : make_hit[KEY_RIGHT]  = 1'b1;
         `SC_MAKE_UP     : make_hit[KEY_UP]     = 1'b1;
         `SC_MAKE_DOWN   : make_hit[KEY_DOWN]   = 1'b1;
         `SC_BREAK_1     : break_hit[KEY_1]     = 1'b1;
         `SC_BREAK_2     : break_hit[KEY_2]     = 1'b1;
         `SC_BREAK_3     : break_hit[KEY_3]     = 1'b1;
         `SC_BREAK_4     : break_hit[KEY_4]     = 1'b1;
         `SC_BREAK_5     : break_hit[KEY_5]     = 1'b1;
         `SC_BREAK_6     : break_hit[KEY_6]     = 1'b1;
         `SC_BREAK_7     : break_hit[KEY_7]     = 1'b1;
         `SC_BREAK_8     : break_hit[KEY_8]     = 1'b1;
         `SC_BREAK_F1    : break_hit[KEY_F1]    = 1'b1;
         `SC_BREAK_F2    : break_hit[KEY_F2]    = 1'b1;
         `SC_BREAK_N     : break_hit[KEY_N]     = 1'b1;
         `SC_BREAK_M     : break_hit[KEY_M]     = 1'b1;
         `SC_BREAK_SPACE : break_hit[KEY_SPACE] = 1'b1;
         `SC_BREAK_LEFT  : break_hit[KEY_LEFT]  = 1'b1;
         `SC_BREAK_RIGHT : break_hit[KEY_RIGHT] = 1'b1;
         `SC_BREAK_UP    : break_hit[KEY_UP]    = 1'b1;
         `SC_BREAK_DOWN  : break_hit[KEY_DOWN]  = 1'b1;
         default         : ;                    // unrelated code, no change
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         held_keys <= '0;
      else if (event_valid)
         held_keys <= (held_keys | make_hit) & ~break_hit;
   end

endmodule

// File: logic/lfsr_gen.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module lfsr_gen
(
   input  logic CLK_25MHZ,
   input  logic reset_from_key,
   input  logic bit_tick,
   output logic data_bit
);

   localparam logic [`DDS_LFSR_W-1:0] SEED = `DDS_LFSR_W'(1);

   logic [`DDS_LFSR_W-1:0] lfsr_state;
   logic                   feedback;

   // x^5 + x^3 + 1, maximal length, 31 states
   assign feedback = lfsr_state[`DDS_LFSR_W-1] ^ lfsr_state[2];

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         lfsr_state <= SEED;
      else if (bit_tick)
         lfsr_state <= {lfsr_state[`DDS_LFSR_W-2:0], feedback};
   end

   assign data_bit = lfsr_state[0];   // modulating data

endmodule

// File: logic/modulator.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module modulator
   import dds_pkg::*;
(
   input  logic                     CLK_25MHZ,
   input  logic                     reset_from_key,
   input  logic [`DDS_SAMPLE_W-1:0] carrier,
   input  logic                     data_bit,
   input  mod_sel_t                 mod_sel,
   output logic [`DDS_SAMPLE_W-1:0] carrier_out,
   output logic [`DDS_SAMPLE_W-1:0] mod_out
);

   localparam logic [`DDS_SAMPLE_W-1:0] NEG_FULL = {1'b1, {(`DDS_SAMPLE_W-1){1'b0}}};  // -2048

   logic [`DDS_SAMPLE_W-1:0] ask_sample;
   logic [`DDS_SAMPLE_W-1:0] bpsk_sample;
   logic [`DDS_SAMPLE_W-1:0] bit_sample;
   logic [`DDS_SAMPLE_W-1:0] mod_next;

   assign ask_sample  = data_bit ? carrier : '0;                  // on/off keying
   assign bpsk_sample = data_bit ? (~carrier + 1'b1) : carrier;   // -2048 wraps to itself
   assign bit_sample  = data_bit ? NEG_FULL : '0;                 // raw data for display

   always_comb
   begin
      case (mod_sel)
         MOD_ASK  : mod_next = ask_sample;
         MOD_BPSK : mod_next = bpsk_sample;
         MOD_BIT  : mod_next = bit_sample;
         default  : mod_next = carrier;   // MOD_CARRIER
      endcase
   end

   ////////////////////
   // output registers
   ////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         carrier_out <= '0;
         mod_out     <= '0;
      end
      else
      begin
         carrier_out <= carrier;
         mod_out     <= mod_next;
      end
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the DDS lab testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
      --top-module dds_lab_tb -f tb.f \
      -Mdir obj_dir -o dds_lab_sim
then
   echo "verilator build failed"
   exit 1
fi

if ! ./obj_dir/dds_lab_sim
then
   echo "simulation reported failure"
   exit 1
fi

exit 0

// File: tb.f
+incdir+logic
logic/dds_pkg.sv
logic/key_tracker.sv
logic/bit_rate_timer.sv
logic/lfsr_gen.sv
logic/dds_core.sv
logic/modulator.sv
logic/dds_lab_top.sv
tb/dds_lab_asserts.sv
tb/dds_lab_tb.sv

// File: tb/dds_lab_asserts.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module dds_lab_asserts
(
   input logic                     CLK_25MHZ,
   input logic                     reset_from_key,
   input logic                     bit_tick,
   input logic [`DDS_LFSR_W-1:0]   lfsr_state,
   input logic                     data_bit,
   input logic [`DDS_NUM_KEYS-1:0] held_keys
);

   tick_one_cycle : assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      bit_tick |=> !bit_tick
   ) else $error("bit_tick high for more than one cycle");

   // all-zero state would lock up
   lfsr_nonzero : assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr_state != '0
   ) else $error("LFSR reached the all-zero state");

   bit_moves_on_tick : assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      !bit_tick |=> $stable(data_bit)   // data only moves after a tick
   ) else $error("data_bit changed without a tick");

   held_clear_in_reset : assert property (
      @(posedge CLK_25MHZ)
      reset_from_key |=> held_keys == '0
   ) else $error("held_keys not zero in reset");

endmodule

bind dds_lab_top dds_lab_asserts u_asserts (
   .CLK_25MHZ      (CLK_25MHZ),
   .reset_from_key (reset_from_key),
   .bit_tick       (bit_tick),
   .lfsr_state     (u_lfsr.lfsr_state),
   .data_bit       (data_bit),
   .held_keys      (held_keys)
);

// File: tb/dds_lab_tb.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module dds_lab_tb
   import dds_pkg::*;
();

   localparam int CLK_NS      = 40;
   localparam int RESET_CYC   = 8;
   localparam int P           = `DDS_BIT_PERIOD;
   localparam int RUN_CYC     = RESET_CYC + 2 + 400 + 4 * 200 + 62 * P + 400 + 3;
   localparam int WATCHDOG_NS = (RUN_CYC + 200) * CLK_NS;

   // event codes by held_keys bit position, DOWN at bit 0
   localparam logic [7:0] MAKE_CODES [0:16] = '{
      `SC_MAKE_DOWN, `SC_MAKE_UP, `SC_MAKE_RIGHT, `SC_MAKE_LEFT, `SC_MAKE_SPACE,
      `SC_MAKE_M, `SC_MAKE_N, `SC_MAKE_F2, `SC_MAKE_F1, `SC_MAKE_8, `SC_MAKE_7,
      `SC_MAKE_6, `SC_MAKE_5, `SC_MAKE_4, `SC_MAKE_3, `SC_MAKE_2, `SC_MAKE_1
   };
   localparam logic [7:0] BREAK_CODES [0:16] = '{
      `SC_BREAK_DOWN, `SC_BREAK_UP, `SC_BREAK_RIGHT, `SC_BREAK_LEFT, `SC_BREAK_SPACE,
      `SC_BREAK_M, `SC_BREAK_N, `SC_BREAK_F2, `SC_BREAK_F1, `SC_BREAK_8, `SC_BREAK_7,
      `SC_BREAK_6, `SC_BREAK_5, `SC_BREAK_4, `SC_BREAK_3, `SC_BREAK_2, `SC_BREAK_1
   };

   logic                     CLK_25MHZ = 1'b0;
   logic                     reset_from_key;
   logic [`DDS_PHASE_W-1:0]  phase_inc;
   wave_sel_t                wave_sel;
   mod_sel_t                 mod_sel;
   logic                     event_valid;
   logic [`DDS_CODE_W-1:0]   event_code;
   logic [`DDS_NUM_KEYS-1:0] held_keys;
   logic                     data_bit;
   logic [`DDS_SAMPLE_W-1:0] carrier_out;
   logic [`DDS_SAMPLE_W-1:0] mod_out;

   logic [31:0] lcg_state = 32'd64;
   logic [31:0] m_phase;        // model phase accumulator
   logic [4:0]  m_lfsr;
   logic [16:0] m_held;
   logic [11:0] exp_carrier;    // expected after the next edge
   logic [11:0] exp_mod;
   int          m_count;        // edges since reset release
   bit          model_live = 1'b0;
   int          bpsk_wrap_hits = 0;
   logic        bit_samples [0:61];

   dds_lab_top dut (.*);

   always #(CLK_NS / 2) CLK_25MHZ = ~CLK_25MHZ;

   ////////////////////
   // reference model
   ////////////////////

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [11:0] ref_carrier(logic [31:0] phase, wave_sel_t wave);
      if (wave == WAVE_SQUARE)
         return phase[31] ? 12'h800 : 12'h7FF;   // -2048 or +2047
      return phase[31:20];                       // ramp from the top bits
   endfunction

   function automatic logic [11:0] ref_mod(logic [11:0] c, logic b, mod_sel_t sel);
      case (sel)
         MOD_ASK  : return b ? c : 12'h000;
         MOD_BPSK : return b ? 12'h000 - c : c;   // wraps at full scale
         MOD_BIT  : return b ? 12'h800 : 12'h000;
         default  : return c;
      endcase
   endfunction

   function automatic logic [4:0] ref_lfsr_step(logic [4:0] s);
      return {s[3:0], s[4] ^ s[2]};   // taps 5 and 3
   endfunction

   function automatic logic [16:0] ref_held(logic [16:0] held, logic [7:0] code);
      logic [16:0] next;
      int          i;
      next = held;
      for (i = 0; i < `DDS_NUM_KEYS; i++)
      begin
         if (code == MAKE_CODES[i])
            next[i] = 1'b1;
         if (code == BREAK_CODES[i])
            next[i] = 1'b0;
      end
      return next;
   endfunction

   task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("[ERROR] time %0t: %s expected 0x%0h, got 0x%0h",
                  $time, name, expected, actual);
         $display("RESULT: FAIL");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic stop_run(string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "%s", why);
   endtask

   task automatic check_quiet();
      check_value("carrier_out", 32'd0, 32'(carrier_out));
      check_value("mod_out", 32'd0, 32'(mod_out));
      check_value("held_keys", 32'd0, 32'(held_keys));
      check_value("data_bit", 32'd1, 32'(data_bit));
   endtask

   ////////////////////
   // comparing process
   ////////////////////

   always @(posedge CLK_25MHZ)
   begin
      logic [11:0] c;
      if (model_live)
      begin
         check_value("carrier_out", 32'(exp_carrier), 32'(carrier_out));
         check_value("mod_out", 32'(exp_mod), 32'(mod_out));
         check_value("data_bit", 32'(m_lfsr[0]), 32'(data_bit));
         check_value("held_keys", 32'(m_held), 32'(held_keys));
      end
      if (reset_from_key)
      begin
         m_phase     = '0;
         m_lfsr      = 5'b00001;
         m_held      = '0;
         exp_carrier = '0;
         exp_mod     = '0;
         m_count     = 0;
         model_live  = 1'b1;
      end
      else
      begin
         c           = ref_carrier(m_phase, wave_sel);
         exp_carrier = c;
         exp_mod     = ref_mod(c, m_lfsr[0], mod_sel);
         if (mod_sel == MOD_BPSK && c == 12'h800 && m_lfsr[0])
            bpsk_wrap_hits++;
         m_phase = m_phase + phase_inc;
         if (m_count > 0 && m_count % P == 0)
            m_lfsr = ref_lfsr_step(m_lfsr);   // tick seen this edge
         m_count++;
         if (event_valid)
            m_held = ref_held(m_held, event_code);
      end
   end

   ////////////////////
   // stimulus
   ////////////////////

   initial
   begin
      logic [31:0] r;
      int          k;
      int          m;
      int          idx;
      int          ones;
      reset_from_key = 1'b1;
      phase_inc      = '0;
      wave_sel       = WAVE_SAW;
      mod_sel        = MOD_CARRIER;
      event_valid    = 1'b0;
      event_code     = '0;
      repeat (RESET_CYC) @(negedge CLK_25MHZ);
      check_quiet();   // still in reset
      reset_from_key = 1'b0;
      @(negedge CLK_25MHZ);
      check_quiet();   // first sample after release

      // random carriers
      for (k = 0; k < 400; k++)
      begin
         r = next_rand();
         if (k % 8 == 0)
            phase_inc = next_rand();
         wave_sel = r[5] ? WAVE_SQUARE : WAVE_SAW;
         @(negedge CLK_25MHZ);
      end

      // each modulation, full-scale square first
      for (m = 0; m < 4; m++)
      begin
         mod_sel = mod_sel_t'(m[1:0]);
         for (k = 0; k < 200; k++)
         begin
            if (k < 150)
            begin
               wave_sel  = WAVE_SQUARE;
               phase_inc = 32'h8000_0000;   // toggles the phase MSB
            end
            else
            begin
               wave_sel = WAVE_SAW;
               if (k % 10 == 0)
                  phase_inc = next_rand();
            end
            @(negedge CLK_25MHZ);
         end
      end

      // data bit sequence, one sample per bit
      mod_sel = MOD_BIT;
      for (k = 0; k < 62; k++)
      begin
         bit_samples[k] = data_bit;
         repeat (P) @(negedge CLK_25MHZ);
      end
      ones = 0;
      for (k = 0; k < 31; k++)
      begin
         check_value("data_bit", 32'(bit_samples[k]), 32'(bit_samples[k + 31]));
         if (bit_samples[k])
            ones++;
      end
      check_value("data_bit ones per period", 32'd16, 32'(ones));

      // key events, make codes favoured so keys pile up
      for (k = 0; k < 400; k++)
      begin
         r           = next_rand();
         idx         = int'(r[15:8]) % `DDS_NUM_KEYS;
         event_valid = r[0] | r[1];
         case (r[3:2])
            2'd0, 2'd1 : event_code = MAKE_CODES[idx];
            2'd2       : event_code = BREAK_CODES[idx];
            default    : event_code = r[31:24];   // mostly unrelated
         endcase
         @(negedge CLK_25MHZ);
      end
      event_valid = 1'b0;
      repeat (2) @(negedge CLK_25MHZ);

      if (bpsk_wrap_hits == 0)
         stop_run("BPSK negation of -2048 was never exercised");
      else
      begin
         $display("RESULT: PASS");
         $finish;
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      stop_run("timeout, the stimulus did not finish in time");
   end

endmodule
